//--- issue_stage.f
+incdir+common
common/issue_pkg.sv
common/rf_read_if.sv
regfile/gpr_regfile.sv
logic/hazard_check.sv
logic/operand_select.sv
logic/issue_register.sv
logic/issue_stage.sv
tb/tb_issue_stage.sv

//--- Bender.yml
package:
  name: issue_stage

export_include_dirs:
  - common

sources:
  - common/issue_pkg.sv
  - common/rf_read_if.sv
  - regfile/gpr_regfile.sv
  - logic/hazard_check.sv
  - logic/operand_select.sv
  - logic/issue_register.sv
  - logic/issue_stage.sv
  - target: test
    files:
      - tb/tb_issue_stage.sv

//--- tb/tb_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module tb_issue_stage
  import issue_pkg::*;
();

  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned ACK_TIMEOUT  = 20;
  // cycle budget of reset and then of each test in order
  localparam int unsigned TEST_CYCLES  = 20 + 40 + 20 + 10 + 50 + 20 + 20;
  localparam int unsigned WATCHDOG_NS  = TEST_CYCLES * 10 + 2000;

  logic      clk;
  logic      rst_n;
  logic      flush;
  logic      stall;
  logic      instr_valid;
  fu_t       instr_fu;
  fu_op_t    instr_op;
  reg_addr_t instr_rs1;
  reg_addr_t instr_rs2;
  reg_addr_t instr_rd;
  xlen_t     instr_imm;
  vaddr_t    instr_pc;
  logic      use_pc;
  logic      use_imm;
  logic      use_zimm;
  logic      ex_valid;
  trans_id_t instr_trans_id;
  clobber_t  clobber;
  xlen_t     sb_a_data;
  xlen_t     sb_b_data;
  logic      sb_a_valid;
  logic      sb_b_valid;
  logic      flu_ready;
  logic      lsu_ready;
  reg_addr_t [`ISSUE_NR_COMMIT-1:0] commit_waddr;
  xlen_t     [`ISSUE_NR_COMMIT-1:0] commit_wdata;
  logic      [`ISSUE_NR_COMMIT-1:0] commit_we;

  logic      issue_ack;
  logic      stall_issue;
  xlen_t     operand_a;
  xlen_t     operand_b;
  xlen_t     imm;
  fu_t       fu;
  fu_op_t    op;
  trans_id_t trans_id;
  vaddr_t    pc;
  logic      alu_valid;
  logic      branch_valid;
  logic      lsu_valid;
  logic      mult_valid;
  logic      csr_valid;

  // reference model of the register file
  xlen_t  shadow [`ISSUE_NR_REGS];
  integer seed;
  int     errors;
  int     timeouts;

  issue_stage issue_stage_inst (
    .clk_i (clk), .rst_uarch_ni (rst_n), .flush_i (flush), .stall_i (stall),
    .instr_valid_i (instr_valid), .instr_fu_i (instr_fu), .instr_op_i (instr_op),
    .instr_rs1_i (instr_rs1), .instr_rs2_i (instr_rs2), .instr_rd_i (instr_rd),
    .instr_imm_i (instr_imm), .instr_pc_i (instr_pc), .instr_use_pc_i (use_pc),
    .instr_use_imm_i (use_imm), .instr_use_zimm_i (use_zimm),
    .instr_ex_valid_i (ex_valid), .instr_trans_id_i (instr_trans_id),
    .clobber_i (clobber), .sb_a_data_i (sb_a_data), .sb_a_valid_i (sb_a_valid),
    .sb_b_data_i (sb_b_data), .sb_b_valid_i (sb_b_valid),
    .flu_ready_i (flu_ready), .lsu_ready_i (lsu_ready),
    .commit_waddr_i (commit_waddr), .commit_wdata_i (commit_wdata),
    .commit_we_i (commit_we), .issue_ack_o (issue_ack), .stall_issue_o (stall_issue),
    .operand_a_o (operand_a), .operand_b_o (operand_b), .imm_o (imm), .fu_o (fu),
    .op_o (op), .trans_id_o (trans_id), .pc_o (pc), .alu_valid_o (alu_valid),
    .branch_valid_o (branch_valid), .lsu_valid_o (lsu_valid),
    .mult_valid_o (mult_valid), .csr_valid_o (csr_valid)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_xlen(input xlen_t got, input xlen_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_fu(input fu_t got, input fu_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED @%0t: %s got %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_op(input fu_op_t got, input fu_op_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED @%0t: %s got %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_tid(input trans_id_t got, input trans_id_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED @%0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_pc(input vaddr_t got, input vaddr_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // only the strobe of the given unit may be high
  // NONE expects every strobe low
  task automatic check_strobes(input fu_t unit, input string what);
    check_bit(alu_valid, unit == ALU, {what, " alu_valid"});
    check_bit(branch_valid, unit == CTRL_FLOW, {what, " branch_valid"});
    check_bit(lsu_valid, (unit == LOAD) || (unit == STORE), {what, " lsu_valid"});
    check_bit(mult_valid, unit == MULT, {what, " mult_valid"});
    check_bit(csr_valid, unit == CSR, {what, " csr_valid"});
  endtask

  // ------------------------------
  // drivers and model
  // ------------------------------
  task automatic step();
    @(negedge clk);
  endtask

  function automatic xlen_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic idle_instr();
    instr_valid    = 1'b0;
    instr_fu       = NONE;
    instr_op       = ADD;
    instr_rs1      = '0;
    instr_rs2      = '0;
    instr_rd       = '0;
    instr_imm      = '0;
    instr_pc       = '0;
    use_pc         = 1'b0;
    use_imm        = 1'b0;
    use_zimm       = 1'b0;
    ex_valid       = 1'b0;
    instr_trans_id = '0;
  endtask

  task automatic clear_scoreboard();
    for (int r = 0; r < `ISSUE_NR_REGS; r++) begin
      clobber[r] = NONE;
    end
    sb_a_valid = 1'b0;
    sb_b_valid = 1'b0;
  endtask

  task automatic offer(input fu_t f, input reg_addr_t rs1, input reg_addr_t rs2,
                       input reg_addr_t rd);
    idle_instr();
    instr_valid    = 1'b1;
    instr_fu       = f;
    instr_rs1      = rs1;
    instr_rs2      = rs2;
    instr_rd       = rd;
    instr_trans_id = trans_id_t'(rd);
    // a typical opcode per unit, passed through untouched
    case (f)
      ALU:       instr_op = SUB;
      CTRL_FLOW: instr_op = JALR;
      CSR:       instr_op = CSRRW;
      MULT:      instr_op = MUL;
      LOAD:      instr_op = LD;
      STORE:     instr_op = SD;
      default:   instr_op = ADD;
    endcase
  endtask

  // both ports write in one cycle
  // port 1 wins a collision
  task automatic commit_write(input reg_addr_t a0, input xlen_t d0,
                              input reg_addr_t a1, input xlen_t d1);
    commit_waddr[0] = a0;
    commit_wdata[0] = d0;
    commit_waddr[1] = a1;
    commit_wdata[1] = d1;
    commit_we       = 2'b11;
    step();
    commit_we = 2'b00;
    if (a0 != 0) shadow[a0] = d0;
    if (a1 != 0) shadow[a1] = d1;
  endtask

  task automatic wait_ack(input string what);
    int n;
    n = 0;
    #1;
    while (!issue_ack && (n < ACK_TIMEOUT)) begin
      step();
      #1;
      n++;
    end
    if (!issue_ack) begin
      timeouts++;
      $display("timeout: issue_ack_o never rose for %s", what);
    end
  endtask

  // offer and wait for the ack, then check payload and a single strobe
  task automatic issue_and_check(input fu_t f, input reg_addr_t rs1, input reg_addr_t rs2,
                                 input reg_addr_t rd, input xlen_t exp_a,
                                 input xlen_t exp_b, input string what);
    offer(f, rs1, rs2, rd);
    wait_ack(what);
    step();
    check_xlen(operand_a, exp_a, {what, " operand_a"});
    check_xlen(operand_b, exp_b, {what, " operand_b"});
    check_fu(fu, f, {what, " fu"});
    check_op(op, instr_op, {what, " op"});
    check_tid(trans_id, trans_id_t'(rd), {what, " trans_id"});
    check_strobes(f, what);
    idle_instr();
    step();
    check_strobes(NONE, {what, " strobe end"});
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_regfile_read();
    reg_addr_t r;
    for (int i = 0; i < 4; i++) begin
      r = reg_addr_t'(4 * i + 3);
      commit_write(r, rand_word(), r + 5'd1, rand_word());
      issue_and_check(ALU, r, r + 5'd1, r + 5'd2, shadow[r], shadow[r + 1], "rf read");
    end
    commit_write(5'd9, rand_word(), 5'd9, rand_word());
    issue_and_check(ALU, 5'd9, 5'd0, 5'd1, shadow[9], '0, "rf collision");
    issue_and_check(ALU, 5'd0, 5'd3, 5'd1, '0, shadow[3], "rf x0");
  endtask

  task automatic test_forward_stall();
    xlen_t da;
    xlen_t db;
    da = rand_word();
    db = rand_word();
    offer(ALU, 5'd4, 5'd5, 5'd20);
    clobber[4] = ALU;
    clobber[5] = LOAD;
    sb_a_valid = 1'b1;
    sb_b_valid = 1'b1;
    sb_a_data  = da;
    sb_b_data  = db;
    #1;
    check_bit(issue_ack, 1'b1, "fwd ack");
    check_bit(stall_issue, 1'b0, "fwd stall");
    step();
    check_xlen(operand_a, da, "fwd operand_a");
    check_xlen(operand_b, db, "fwd operand_b");
    // scoreboard value of rs1 not produced yet
    sb_a_valid = 1'b0;
    #1;
    check_bit(issue_ack, 1'b0, "sb invalid ack");
    check_bit(stall_issue, 1'b1, "sb invalid stall");
    step();
    // csr result cannot be forwarded
    sb_a_valid = 1'b1;
    clobber[4] = CSR;
    #1;
    check_bit(issue_ack, 1'b0, "csr clobber ack");
    check_bit(stall_issue, 1'b1, "csr clobber stall");
    idle_instr();
    clear_scoreboard();
    step();
    step();
  endtask

  task automatic test_waw();
    xlen_t d;
    d = rand_word();
    offer(ALU, 5'd3, 5'd4, 5'd12);
    clobber[12] = MULT;
    #1;
    check_bit(issue_ack, 1'b0, "waw blocked ack");
    check_bit(stall_issue, 1'b0, "waw no stall");
    step();
    check_strobes(NONE, "waw blocked");
    // the pending writer of rd commits in this cycle
    commit_waddr[1] = 5'd12;
    commit_wdata[1] = d;
    commit_we       = 2'b10;
    #1;
    check_bit(issue_ack, 1'b1, "waw commit ack");
    step();
    commit_we  = 2'b00;
    shadow[12] = d;
    check_strobes(ALU, "waw");
    idle_instr();
    clear_scoreboard();
    step();
  endtask

  task automatic test_busy_accept();
    fu_t units [6];
    units = '{ALU, CTRL_FLOW, CSR, MULT, LOAD, STORE};
    lsu_ready = 1'b0;
    offer(LOAD, 5'd6, 5'd0, 5'd21);
    repeat (3) begin
      #1;
      check_bit(issue_ack, 1'b0, "lsu busy ack");
      step();
    end
    lsu_ready = 1'b1;
    wait_ack("load after busy");
    step();
    check_strobes(LOAD, "load after busy");
    // stall_i alone holds a normal instruction
    stall = 1'b1;
    offer(ALU, 5'd1, 5'd2, 5'd22);
    #1;
    check_bit(issue_ack, 1'b0, "stall_i ack");
    check_bit(stall_issue, 1'b1, "stall_i stall");
    step();
    // busy units on top of the stall
    flu_ready = 1'b0;
    lsu_ready = 1'b0;
    offer(NONE, 5'd1, 5'd2, 5'd22);
    #1;
    check_bit(issue_ack, 1'b1, "fu none ack");
    step();
    check_strobes(NONE, "fu none");
    offer(ALU, 5'd1, 5'd2, 5'd22);
    ex_valid = 1'b1;
    #1;
    check_bit(issue_ack, 1'b1, "exception ack");
    step();
    check_strobes(NONE, "exception");
    idle_instr();
    flu_ready = 1'b1;
    lsu_ready = 1'b1;
    stall     = 1'b0;
    step();
    foreach (units[i]) begin
      issue_and_check(units[i], 5'd1, 5'd2, 5'd13, shadow[1], shadow[2], "unit strobe");
    end
  endtask

  task automatic test_mult_flush();
    offer(MULT, 5'd1, 5'd2, 5'd14);
    wait_ack("first mult");
    step();
    check_bit(mult_valid, 1'b1, "first mult strobe");
    // a multiply may follow a multiply
    offer(MULT, 5'd1, 5'd2, 5'd15);
    #1;
    check_bit(issue_ack, 1'b1, "mult behind mult ack");
    step();
    check_bit(mult_valid, 1'b1, "second mult strobe");
    // fixed-latency bus taken by the multiply
    offer(ALU, 5'd1, 5'd2, 5'd15);
    #1;
    check_bit(issue_ack, 1'b0, "alu behind mult ack");
    step();
    check_strobes(NONE, "mult strobe end");
    offer(ALU, 5'd1, 5'd2, 5'd15);
    flush = 1'b1;
    #1;
    check_bit(issue_ack, 1'b1, "flush ack");
    step();
    check_strobes(NONE, "flush");
    flush = 1'b0;
    idle_instr();
    step();
  endtask

  task automatic test_operand_sources();
    vaddr_t pcv;
    xlen_t  immv;
    pcv  = 39'h40_8000_1234;
    immv = rand_word();
    offer(ALU, 5'd3, 5'd4, 5'd16);
    use_pc   = 1'b1;
    instr_pc = pcv;
    wait_ack("use_pc");
    step();
    // pc bit 38 is set and fills the upper bits with ones
    check_xlen(operand_a, 64'hFFFF_FFC0_8000_1234, "use_pc a");
    check_pc(pc, pcv, "use_pc pc");
    // zimm beats pc and skips the rs1 clobber
    offer(CSR, 5'd19, 5'd0, 5'd17);
    use_zimm    = 1'b1;
    use_pc      = 1'b1;
    clobber[19] = CSR;
    #1;
    check_bit(issue_ack, 1'b1, "zimm ack");
    check_bit(stall_issue, 1'b0, "zimm stall");
    step();
    check_xlen(operand_a, 64'd19, "zimm a");
    clear_scoreboard();
    offer(ALU, 5'd3, 5'd4, 5'd18);
    use_imm   = 1'b1;
    instr_imm = immv;
    wait_ack("alu imm");
    step();
    check_xlen(operand_b, immv, "alu imm b");
    check_xlen(imm, immv, "alu imm_o");
    offer(STORE, 5'd3, 5'd4, 5'd0);
    use_imm   = 1'b1;
    instr_imm = immv;
    wait_ack("store imm");
    step();
    check_xlen(operand_b, shadow[4], "store b keeps rs2");
    check_xlen(imm, immv, "store imm_o");
    idle_instr();
    step();
  endtask

  // ------------------------------
  // sequence
  // ------------------------------
  initial begin : main
    seed         = 32'hd75a;
    errors       = 0;
    timeouts     = 0;
    rst_n        = 1'b0;
    flush        = 1'b0;
    stall        = 1'b0;
    flu_ready    = 1'b1;
    lsu_ready    = 1'b1;
    sb_a_data    = '0;
    sb_b_data    = '0;
    commit_waddr = '0;
    commit_wdata = '0;
    commit_we    = '0;
    idle_instr();
    clear_scoreboard();
    for (int r = 0; r < `ISSUE_NR_REGS; r++) begin
      shadow[r] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    step();
    check_strobes(NONE, "reset");
    check_fu(fu, NONE, "reset fu");
    check_xlen(operand_a, '0, "reset operand_a");
    check_xlen(operand_b, '0, "reset operand_b");
    check_xlen(imm, '0, "reset imm");
    check_pc(pc, '0, "reset pc");
    rst_n = 1'b1;
    step();
    test_regfile_read();
    test_forward_stall();
    test_waw();
    test_busy_accept();
    test_mult_flush();
    test_operand_sources();
    $display("errors: %0d value mismatches, %0d ack timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t before the tests finished", $time);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module issue_stage
  import issue_pkg::*;
(
  input  wire logic                        clk_i,
  input  wire logic                        rst_uarch_ni,
  input  wire logic                        flush_i,
  input  wire logic                        stall_i,
  // instruction from the scoreboard
  input  wire logic                        instr_valid_i,
  input  fu_t                              instr_fu_i,
  input  fu_op_t                           instr_op_i,
  input  reg_addr_t                        instr_rs1_i,
  input  reg_addr_t                        instr_rs2_i,
  input  reg_addr_t                        instr_rd_i,
  input  xlen_t                            instr_imm_i,
  input  vaddr_t                           instr_pc_i,
  input  wire logic                        instr_use_pc_i,
  input  wire logic                        instr_use_imm_i,
  input  wire logic                        instr_use_zimm_i,
  input  wire logic                        instr_ex_valid_i,
  input  trans_id_t                        instr_trans_id_i,
  // scoreboard state and forwarding data
  input  clobber_t                         clobber_i,
  input  xlen_t                            sb_a_data_i,
  input  wire logic                        sb_a_valid_i,
  input  xlen_t                            sb_b_data_i,
  input  wire logic                        sb_b_valid_i,
  input  wire logic                        flu_ready_i,
  input  wire logic                        lsu_ready_i,
  // commit write-back
  input  reg_addr_t [`ISSUE_NR_COMMIT-1:0] commit_waddr_i,
  input  xlen_t     [`ISSUE_NR_COMMIT-1:0] commit_wdata_i,
  input  wire logic [`ISSUE_NR_COMMIT-1:0] commit_we_i,
  output logic                             issue_ack_o,
  output logic                             stall_issue_o,
  // ID/EX outputs
  output xlen_t                            operand_a_o,
  output xlen_t                            operand_b_o,
  output xlen_t                            imm_o,
  output fu_t                              fu_o,
  output fu_op_t                           op_o,
  output trans_id_t                        trans_id_o,
  output vaddr_t                           pc_o,
  output logic                             alu_valid_o,
  output logic                             branch_valid_o,
  output logic                             lsu_valid_o,
  output logic                             mult_valid_o,
  output logic                             csr_valid_o
);

  issue_instr_t instr;
  logic         fwd_a;
  logic         fwd_b;
  logic         mult_pending;
  xlen_t        operand_a;
  xlen_t        operand_b;
  xlen_t        imm;

  rf_read_if rf_rd ();

  // gather the flat ports into one instruction
  always_comb begin
    instr.fu       = instr_fu_i;
    instr.op       = instr_op_i;
    instr.rs1      = instr_rs1_i;
    instr.rs2      = instr_rs2_i;
    instr.rd       = instr_rd_i;
    instr.imm      = instr_imm_i;
    instr.pc       = instr_pc_i;
    instr.use_pc   = instr_use_pc_i;
    instr.use_imm  = instr_use_imm_i;
    instr.use_zimm = instr_use_zimm_i;
    instr.ex_valid = instr_ex_valid_i;
    instr.trans_id = instr_trans_id_i;
  end

  // ------------------------------
  // read operands
  // ------------------------------
  gpr_regfile gpr_regfile_inst (
    .clk_i          (clk_i),
    .rst_uarch_ni   (rst_uarch_ni),
    .commit_waddr_i (commit_waddr_i),
    .commit_wdata_i (commit_wdata_i),
    .commit_we_i    (commit_we_i),
    .rd_port        (rf_rd.regfile)
  );

  hazard_check hazard_check_inst (
    .instr_i        (instr),
    .instr_valid_i  (instr_valid_i),
    .clobber_i      (clobber_i),
    .sb_a_valid_i   (sb_a_valid_i),
    .sb_b_valid_i   (sb_b_valid_i),
    .flu_ready_i    (flu_ready_i),
    .lsu_ready_i    (lsu_ready_i),
    .stall_i        (stall_i),
    .mult_pending_i (mult_pending),
    .commit_waddr_i (commit_waddr_i),
    .commit_we_i    (commit_we_i),
    .fwd_a_o        (fwd_a),
    .fwd_b_o        (fwd_b),
    .stall_o        (stall_issue_o),
    .issue_ack_o    (issue_ack_o)
  );

  operand_select operand_select_inst (
    .instr_i     (instr),
    .fwd_a_i     (fwd_a),
    .fwd_b_i     (fwd_b),
    .sb_a_data_i (sb_a_data_i),
    .sb_b_data_i (sb_b_data_i),
    .rd_port     (rf_rd.reader),
    .operand_a_o (operand_a),
    .operand_b_o (operand_b),
    .imm_o       (imm)
  );

  // ------------------------------
  // ID/EX register
  // ------------------------------
  issue_register issue_register_inst (
    .clk_i          (clk_i),
    .rst_uarch_ni   (rst_uarch_ni),
    .flush_i        (flush_i),
    .instr_i        (instr),
    .instr_valid_i  (instr_valid_i),
    .issue_ack_i    (issue_ack_o),
    .operand_a_i    (operand_a),
    .operand_b_i    (operand_b),
    .imm_i          (imm),
    .operand_a_o    (operand_a_o),
    .operand_b_o    (operand_b_o),
    .imm_o          (imm_o),
    .fu_o           (fu_o),
    .op_o           (op_o),
    .trans_id_o     (trans_id_o),
    .pc_o           (pc_o),
    .alu_valid_o    (alu_valid_o),
    .branch_valid_o (branch_valid_o),
    .lsu_valid_o    (lsu_valid_o),
    .mult_valid_o   (mult_valid_o),
    .csr_valid_o    (csr_valid_o),
    .mult_pending_o (mult_pending)
  );

endmodule

`default_nettype wire

//--- logic/issue_register.sv
`timescale 1ns/1ps
`default_nettype none

module issue_register
  import issue_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   rst_uarch_ni,
  input  wire logic   flush_i,
  input  issue_instr_t instr_i,
  input  wire logic   instr_valid_i,
  input  wire logic   issue_ack_i,
  // selected operands
  input  xlen_t       operand_a_i,
  input  xlen_t       operand_b_i,
  input  xlen_t       imm_i,
  // ID/EX payload
  output xlen_t       operand_a_o,
  output xlen_t       operand_b_o,
  output xlen_t       imm_o,
  output fu_t         fu_o,
  output fu_op_t      op_o,
  output trans_id_t   trans_id_o,
  output vaddr_t      pc_o,
  // per-unit strobes
  output logic        alu_valid_o,
  output logic        branch_valid_o,
  output logic        lsu_valid_o,
  output logic        mult_valid_o,
  output logic        csr_valid_o,
  output logic        mult_pending_o
);

  logic accept;

  // exceptions are acked but never start a unit
  assign accept = instr_valid_i && issue_ack_i && !instr_i.ex_valid;

  // ------------------------------
  // unit strobes
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      alu_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
      lsu_valid_o    <= 1'b0;
      mult_valid_o   <= 1'b0;
      csr_valid_o    <= 1'b0;
    end else begin
      // one-cycle pulses, cleared by default
      alu_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
      lsu_valid_o    <= 1'b0;
      mult_valid_o   <= 1'b0;
      csr_valid_o    <= 1'b0;
      // a flush drops the strobe so no unit starts on stale operands
      if (accept && !flush_i) begin
        case (instr_i.fu)
          ALU:         alu_valid_o    <= 1'b1;
          CTRL_FLOW:   branch_valid_o <= 1'b1;
          MULT:        mult_valid_o   <= 1'b1;
          LOAD, STORE: lsu_valid_o    <= 1'b1;
          CSR:         csr_valid_o    <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // hazard check blocks alu-type issue behind a multiply
  assign mult_pending_o = mult_valid_o;

  // ------------------------------
  // payload, loaded every cycle
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      operand_a_o <= '0;
      operand_b_o <= '0;
      imm_o       <= '0;
      fu_o        <= NONE;
      op_o        <= ADD;
      trans_id_o  <= '0;
      pc_o        <= '0;
    end else begin
      operand_a_o <= operand_a_i;
      operand_b_o <= operand_b_i;
      imm_o       <= imm_i;
      fu_o        <= instr_i.fu;
      op_o        <= instr_i.op;
      trans_id_o  <= instr_i.trans_id;
      pc_o        <= instr_i.pc;
    end
  end

endmodule

`default_nettype wire

//--- logic/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module operand_select
  import issue_pkg::*;
(
  input  issue_instr_t      instr_i,
  // forwarding decision from the hazard check
  input  wire logic         fwd_a_i,
  input  wire logic         fwd_b_i,
  // scoreboard values
  input  xlen_t             sb_a_data_i,
  input  xlen_t             sb_b_data_i,
  rf_read_if.reader         rd_port,
  output xlen_t             operand_a_o,
  output xlen_t             operand_b_o,
  output xlen_t             imm_o
);

  // register file is polled straight from the source indices
  assign rd_port.raddr_a = instr_i.rs1;
  assign rd_port.raddr_b = instr_i.rs2;

  // ------------------------------
  // operand a
  // ------------------------------
  always_comb begin : sel_a
    if (fwd_a_i) begin
      operand_a_o = sb_a_data_i;
    end else begin
      operand_a_o = rd_port.rdata_a;
    end
    // auipc, jal and friends take the pc, sign extended
    if (instr_i.use_pc) begin
      operand_a_o = {{(`ISSUE_XLEN - `ISSUE_VLEN){instr_i.pc[`ISSUE_VLEN-1]}}, instr_i.pc};
    end
    // csr immediate form, zero extended rs1 index wins over pc
    if (instr_i.use_zimm) begin
      operand_a_o = {{(`ISSUE_XLEN - `ISSUE_REG_ADDR_W){1'b0}}, instr_i.rs1};
    end
  end

  // ------------------------------
  // operand b
  // ------------------------------
  always_comb begin : sel_b
    if (fwd_b_i) begin
      operand_b_o = sb_b_data_i;
    end else begin
      operand_b_o = rd_port.rdata_b;
    end
    // stores and branches keep rs2, their immediate travels in imm_o
    if (instr_i.use_imm && (instr_i.fu != STORE) && (instr_i.fu != CTRL_FLOW)) begin
      operand_b_o = instr_i.imm;
    end
  end

  assign imm_o = instr_i.imm;

endmodule

`default_nettype wire

//--- logic/hazard_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module hazard_check
  import issue_pkg::*;
(
  input  issue_instr_t                     instr_i,
  input  wire logic                        instr_valid_i,
  // scoreboard view
  input  clobber_t                         clobber_i,
  input  wire logic                        sb_a_valid_i,
  input  wire logic                        sb_b_valid_i,
  // unit readiness
  input  wire logic                        flu_ready_i,
  input  wire logic                        lsu_ready_i,
  input  wire logic                        stall_i,
  input  wire logic                        mult_pending_i,
  // commit ports of this cycle
  input  reg_addr_t [`ISSUE_NR_COMMIT-1:0] commit_waddr_i,
  input  wire logic [`ISSUE_NR_COMMIT-1:0] commit_we_i,
  output logic                             fwd_a_o,
  output logic                             fwd_b_o,
  output logic                             stall_o,
  output logic                             issue_ack_o
);

  logic fu_busy;
  logic rd_free;

  // ------------------------------
  // operand availability
  // ------------------------------
  always_comb begin : operand_check
    stall_o = stall_i;
    fwd_a_o = 1'b0;
    fwd_b_o = 1'b0;
    // zimm carries an immediate in rs1, nothing to wait on
    if (!instr_i.use_zimm && (clobber_i[instr_i.rs1] != NONE)) begin
      // csr results only reach the operand through the register file
      if (sb_a_valid_i && (clobber_i[instr_i.rs1] != CSR)) begin
        fwd_a_o = 1'b1;
      end else begin
        stall_o = 1'b1;
      end
    end
    if (clobber_i[instr_i.rs2] != NONE) begin
      if (sb_b_valid_i && (clobber_i[instr_i.rs2] != CSR)) begin
        fwd_b_o = 1'b1;
      end else begin
        stall_o = 1'b1;
      end
    end
  end

  // ------------------------------
  // unit busy
  // ------------------------------
  always_comb begin : unit_busy
    case (instr_i.fu)
      ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~flu_ready_i;
      LOAD, STORE:               fu_busy = ~lsu_ready_i;
      default:                   fu_busy = 1'b0;
    endcase
  end

  // ------------------------------
  // write after write
  // ------------------------------
  always_comb begin : waw_check
    // rd free when nobody in flight targets it
    rd_free = (clobber_i[instr_i.rd] == NONE);
    // or when the pending writer commits right now
    for (int unsigned p = 0; p < `ISSUE_NR_COMMIT; p++) begin
      if (commit_we_i[p] && (commit_waddr_i[p] == instr_i.rd)) begin
        rd_free = 1'b1;
      end
    end
  end

  // ------------------------------
  // acknowledge
  // ------------------------------
  always_comb begin : ack_gen
    issue_ack_o = 1'b0;
    if (instr_valid_i) begin
      if (!stall_o && !fu_busy && rd_free) begin
        issue_ack_o = 1'b1;
      end
      // exceptions and unit-less instructions never wait
      if (instr_i.ex_valid || (instr_i.fu == NONE)) begin
        issue_ack_o = 1'b1;
      end
    end
    // the multiplier owns the fixed-latency bus in the next cycle
    if (mult_pending_i && (instr_i.fu inside {ALU, CTRL_FLOW, CSR})) begin
      issue_ack_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- regfile/gpr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

module gpr_regfile
  import issue_pkg::*;
(
  input  wire logic                             clk_i,
  input  wire logic                             rst_uarch_ni,
  // commit write ports
  input  reg_addr_t [`ISSUE_NR_COMMIT-1:0]      commit_waddr_i,
  input  xlen_t     [`ISSUE_NR_COMMIT-1:0]      commit_wdata_i,
  input  wire logic [`ISSUE_NR_COMMIT-1:0]      commit_we_i,
  // read side
  rf_read_if.regfile                            rd_port
);

  // x0 has no storage, only x1..x31 are kept
  xlen_t mem_q [1:`ISSUE_NR_REGS-1];

  // ------------------------------
  // write
  // ------------------------------

  // decoded per register, so a later port overrides an earlier one
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      for (int unsigned r = 1; r < `ISSUE_NR_REGS; r++) begin
        mem_q[r] <= '0;
      end
    end else begin
      for (int unsigned r = 1; r < `ISSUE_NR_REGS; r++) begin
        for (int unsigned p = 0; p < `ISSUE_NR_COMMIT; p++) begin
          // higher-numbered port wins on a collision
          if (commit_we_i[p] && (commit_waddr_i[p] == reg_addr_t'(r))) begin
            mem_q[r] <= commit_wdata_i[p];
          end
        end
      end
    end
  end

  // ------------------------------
  // read
  // ------------------------------

  // combinational, x0 hard-wired to zero
  always_comb begin
    if (rd_port.raddr_a == '0) begin
      rd_port.rdata_a = '0;
    end else begin
      rd_port.rdata_a = mem_q[rd_port.raddr_a];
    end
  end

  always_comb begin
    if (rd_port.raddr_b == '0) begin
      rd_port.rdata_b = '0;
    end else begin
      rd_port.rdata_b = mem_q[rd_port.raddr_b];
    end
  end

  // a commit write becomes visible from the following cycle,
  // there is no write-to-read bypass here

endmodule

`default_nettype wire

//--- common/rf_read_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_macros.svh"

// two combinational read ports of the register file
interface rf_read_if;

  logic [`ISSUE_REG_ADDR_W-1:0] raddr_a;
  logic [`ISSUE_REG_ADDR_W-1:0] raddr_b;
  logic [`ISSUE_XLEN-1:0]       rdata_a;
  logic [`ISSUE_XLEN-1:0]       rdata_b;

  // storage side, answers in the same cycle
  modport regfile (
    input  raddr_a,
    input  raddr_b,
    output rdata_a,
    output rdata_b
  );

  // requesting side
  modport reader (
    output raddr_a,
    output raddr_b,
    input  rdata_a,
    input  rdata_b
  );

endinterface

`default_nettype wire

//--- common/issue_pkg.sv
`default_nettype none

package issue_pkg;

  `include "issue_macros.svh"

  // ------------------------------
  // scalar types
  // ------------------------------
  typedef logic [`ISSUE_XLEN-1:0] xlen_t;
  typedef logic [`ISSUE_VLEN-1:0] vaddr_t;
  typedef logic [`ISSUE_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`ISSUE_TRANS_ID_W-1:0] trans_id_t;

  // target functional unit of an instruction
  typedef enum logic [2:0] {
    NONE      = 3'd0,
    ALU       = 3'd1,
    CTRL_FLOW = 3'd2,
    CSR       = 3'd3,
    MULT      = 3'd4,
    LOAD      = 3'd5,
    STORE     = 3'd6
  } fu_t;

  // operation code, passed through to the unit untouched
  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    XORL  = 4'd2,
    ORL   = 4'd3,
    ANDL  = 4'd4,
    SLL   = 4'd5,
    SRL   = 4'd6,
    SRA   = 4'd7,
    MUL   = 4'd8,
    LD    = 4'd9,
    SD    = 4'd10,
    JALR  = 4'd11,
    CSRRW = 4'd12
  } fu_op_t;

  // per-register unit that will write that register next
  typedef fu_t [`ISSUE_NR_REGS-1:0] clobber_t;

  // instruction offered to the issue stage
  typedef struct packed {
    fu_t       fu;
    fu_op_t    op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    xlen_t     imm;
    vaddr_t    pc;
    logic      use_pc;
    logic      use_imm;
    logic      use_zimm;
    logic      ex_valid;
    trans_id_t trans_id;
  } issue_instr_t;

endpackage

`default_nettype wire

//--- common/issue_macros.svh
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// ------------------------------
// datapath widths
// ------------------------------

// operand word, rv64
`define ISSUE_XLEN 64
// virtual address width of the pc
`define ISSUE_VLEN 39

// ------------------------------
// register file and commit
// ------------------------------

// general-purpose registers, x0 included
`define ISSUE_NR_REGS 32
`define ISSUE_REG_ADDR_W 5
// commit ports writing back per cycle
`define ISSUE_NR_COMMIT 2
// scoreboard slot tag
`define ISSUE_TRANS_ID_W 3

`endif
